/* hdl/aux_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module aux_registers
    import scan_pkg::*, stream_pkg::*;
(
    input  wire               clock_to_sample,
    input  wire               clock_sense_reset_n_sync,
    input  wire scan_strobe_t scan,
    input  wire ir_code_t     ir,
    output offset_t           offset,
    output logic              reset_request,
    output logic              aux_tdo
);

    logic                     loopback_q;
    logic [INFO_WIDTH-1:0]    info_q;
    logic [CONTROL_WIDTH-1:0] control_q;

    always_ff @(posedge clock_to_sample or negedge clock_sense_reset_n_sync) begin
        if (!clock_sense_reset_n_sync) begin
            loopback_q    <= 1'b0;
            info_q        <= '0;
            control_q     <= '0;
            offset        <= '0;
            reset_request <= 1'b0;
        end else begin
            case (ir)
                IR_LOOPBACK: begin
                    if (scan.capture || scan.shift) begin
                        loopback_q <= scan.shift && scan.tdi; // capture loads 0
                    end
                end
                IR_INFO: begin
                    if (scan.capture) begin
                        info_q <= {INFO_PURPOSE, UP_ENC_SIZE, DOWN_ENC_SIZE};
                    end
                    if (scan.shift) begin
                        info_q <= {1'b0, info_q[INFO_WIDTH-1:1]}; // tdi ignored
                    end
                end
                IR_CONTROL: begin
                    if (scan.capture) begin
                        control_q <= '0;
                    end
                    if (scan.shift) begin
                        control_q <= {scan.tdi, control_q[CONTROL_WIDTH-1:1]};
                    end
                    if (scan.update) begin
                        {reset_request, offset} <= control_q;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (ir)
            IR_LOOPBACK:       aux_tdo = loopback_q;
            IR_INFO:           aux_tdo = info_q[0];
            IR_CONTROL:        aux_tdo = control_q[0];
            IR_DATA, IR_DEBUG: aux_tdo = 1'b0; // data bit comes from the read path
            default:           aux_tdo = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/frame_read_path.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_read_path
    import scan_pkg::*, stream_pkg::*;
(
    input  wire               clock_to_sample,
    input  wire               clock_sense_reset_n_sync,
    input  wire scan_strobe_t scan,
    input  wire               data_selected,
    input  wire offset_t      offset,
    input  wire header_info_t header_info,
    input  wire byte_t        sink_data,
    input  wire               sink_valid,
    output logic              sink_ready,
    output logic              data_tdo
);

    typedef enum logic [1:0] {
        RD_HEADER,
        RD_PADDED,
        RD_DATA
    } read_state_t;

    read_state_t read_state;
    logic [3:0]  status_count;
    pad_count_t  pad_count;
    logic [2:0]  bit_count;
    byte_count_t scan_count;
    len_code_t   read_len;
    logic        read_all;
    logic        read_valid;
    byte_t       data_out;
    byte_t       fetched;
    byte_t       next_byte;
    logic        shifting;
    logic        stream_end;
    logic        in_window;

    assign shifting   = data_selected && scan.shift;
    assign stream_end = (scan_count == '0);
    assign in_window  = read_all ||
                        (read_len != LEN_NONE &&
                         scan_count <= decode_len(read_len) + byte_count_t'(1));
    // a handshake in this very cycle beats the byte held from an earlier one
    assign next_byte  = sink_ready ? (sink_valid ? sink_data : FILL_BYTE) : fetched;
    assign data_tdo   = data_out[0];

    always_ff @(posedge clock_to_sample) begin
        if (sink_ready) begin
            fetched <= next_byte;
        end
    end

    always_ff @(posedge clock_to_sample or negedge clock_sense_reset_n_sync) begin
        if (!clock_sense_reset_n_sync) begin
            read_state   <= RD_HEADER;
            status_count <= '0;
            pad_count    <= '0;
            bit_count    <= '0;
            scan_count   <= '0;
            read_len     <= LEN_NONE;
            read_all     <= 1'b0;
            read_valid   <= 1'b0;
            data_out     <= '0;
            sink_ready   <= 1'b0;
        end else begin
            sink_ready <= 1'b0;
            if (data_selected && scan.capture) begin
                read_state <= RD_HEADER;
                if (offset[2:0] != 3'b000) begin // round up to whole bytes
                    pad_count <= pad_count_t'({offset[7:3], 3'b000}) + pad_count_t'(8);
                end else begin
                    pad_count <= pad_count_t'(offset);
                end
                status_count <= '0;
                bit_count    <= '0;
                data_out     <= byte_t'(sink_valid); // status bit 0
                read_valid   <= 1'b0;
                read_all     <= 1'b0;
            end
            if (shifting) begin
                data_out <= {1'b0, data_out[7:1]};
                case (read_state)
                    RD_HEADER: begin
                        status_count <= status_count - 4'd1;
                        if (status_count == 4'd2 && pad_count == '0) begin
                            sink_ready <= read_all;
                        end
                        if (status_count == 4'd1) begin // last status bit
                            if (pad_count == '0) begin
                                read_state <= RD_DATA;
                                read_valid <= in_window;
                                data_out   <= read_all ? next_byte : FILL_BYTE;
                            end else begin
                                read_state <= RD_PADDED;
                                pad_count  <= pad_count - pad_count_t'(1);
                                data_out   <= FILL_BYTE;
                            end
                        end
                    end
                    RD_PADDED: begin
                        pad_count <= pad_count - pad_count_t'(1);
                        if (pad_count[2:0] == 3'b000) begin
                            data_out <= FILL_BYTE;
                        end
                        if (pad_count == pad_count_t'(1)) begin
                            sink_ready <= read_all;
                        end
                        if (pad_count == '0) begin
                            read_state <= RD_DATA;
                            read_valid <= in_window;
                            data_out   <= read_all ? next_byte : FILL_BYTE;
                        end
                    end
                    RD_DATA: begin
                        bit_count <= bit_count - 3'd1;
                        if (bit_count == 3'd2) begin
                            sink_ready <= read_valid && !stream_end;
                        end
                        if (bit_count == 3'd1) begin
                            if (!stream_end) begin
                                scan_count <= scan_count - byte_count_t'(1);
                            end
                            read_valid <= in_window;
                            data_out   <= (read_valid && !stream_end) ? next_byte : FILL_BYTE;
                        end
                    end
                    default: read_state <= RD_HEADER;
                endcase
            end
            if (header_info.load) begin
                scan_count <= scan_byte_count(header_info.scan_len);
                read_len   <= header_info.read_len;
                read_all   <= (header_info.read_len == LEN_ALL);
            end
        end
    end

    // one fetch per byte, so ready never stays up
    assert property (@(posedge clock_to_sample) disable iff (!clock_sense_reset_n_sync)
        sink_ready |=> !sink_ready);

endmodule

`default_nettype wire

/* hdl/frame_write_path.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_write_path
    import scan_pkg::*, stream_pkg::*;
(
    input  wire               clock_to_sample,
    input  wire               clock_sense_reset_n_sync,
    input  wire scan_strobe_t scan,
    input  wire               data_selected,
    input  wire offset_t      offset,
    output header_info_t      header_info,
    output byte_t             source_data,
    output logic              source_valid
);

    typedef enum logic [1:0] {
        WR_BYPASS,
        WR_HEADER_1,
        WR_HEADER_2,
        WR_DATA
    } write_state_t;

    write_state_t           write_state;
    offset_t                bypass_count;
    logic [3:0]             header_count;
    logic [HEADER_BITS-1:0] header_in;
    scan_len_t              scan_len;
    len_code_t              read_len;
    logic                   header_decoded;
    logic [2:0]             bit_count;
    byte_count_t            write_count;
    byte_t                  data_in;
    len_code_t              write_code;
    logic                   shifting;

    assign shifting   = data_selected && scan.shift;
    assign write_code = {scan.tdi, header_in[15:14]}; // valid on header bit 15

    always_comb begin
        header_info.load     = header_decoded && shifting; // bit 13 shift cycle
        header_info.scan_len = scan_len;
        header_info.read_len = read_len;
    end

    always_ff @(posedge clock_to_sample or negedge clock_sense_reset_n_sync) begin
        if (!clock_sense_reset_n_sync) begin
            write_state    <= WR_BYPASS;
            bypass_count   <= '0;
            header_count   <= '0;
            scan_len       <= '0;
            read_len       <= LEN_NONE;
            header_decoded <= 1'b0;
            bit_count      <= '0;
            write_count    <= '0;
            source_valid   <= 1'b0;
        end else begin
            source_valid <= 1'b0;
            if (data_selected && scan.capture) begin
                write_state    <= (offset == '0) ? WR_HEADER_1 : WR_BYPASS;
                bypass_count   <= offset;
                header_count   <= 4'(HEADER_BITS - 1);
                header_decoded <= 1'b0;
                bit_count      <= '0;
                write_count    <= '0;
            end
            if (shifting) begin
                header_decoded <= 1'b0;
                case (write_state)
                    WR_BYPASS: begin
                        bypass_count <= bypass_count - 8'd1;
                        if (bypass_count == 8'd1) begin
                            write_state <= WR_HEADER_1;
                        end
                    end
                    WR_HEADER_1: begin
                        header_count <= header_count - 4'd1;
                        if (header_count == 4'd3) begin // header bit 12
                            scan_len       <= header_in[13:4];
                            read_len       <= {scan.tdi, header_in[15:14]};
                            header_decoded <= 1'b1;
                            write_state    <= WR_HEADER_2;
                        end
                    end
                    WR_HEADER_2: begin
                        header_count <= header_count - 4'd1;
                        if (header_count == 4'd0) begin
                            if (write_code == LEN_ALL) begin
                                write_count <= scan_byte_count(scan_len) + byte_count_t'(1);
                            end else begin
                                write_count <= decode_len(write_code);
                            end
                            write_state <= WR_DATA;
                        end
                    end
                    WR_DATA: begin
                        bit_count <= bit_count - 3'd1;
                        if (bit_count == 3'd1 && write_count != '0) begin
                            write_count  <= write_count - byte_count_t'(1);
                            source_valid <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // shift registers, no reset needed
    always_ff @(posedge clock_to_sample) begin
        if (shifting) begin
            if (write_state == WR_HEADER_1 || write_state == WR_HEADER_2) begin
                header_in <= {scan.tdi, header_in[HEADER_BITS-1:1]};
            end
            if (write_state == WR_DATA) begin
                data_in <= {scan.tdi, data_in[7:1]};
                if (bit_count == 3'd1 && write_count != '0) begin
                    source_data <= {scan.tdi, data_in[7:1]}; // lsb first
                end
            end
        end
    end

    // a byte only while in data state, and never two in a row
    assert property (@(posedge clock_to_sample) disable iff (!clock_sense_reset_n_sync)
        source_valid |-> (write_state == WR_DATA) ##1 !source_valid);

endmodule

`default_nettype wire

/* hdl/jtag_stream_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_stream_bridge
    import scan_pkg::*, stream_pkg::*;
(
    input  wire               clock_to_sample,
    input  wire               clock_sense_reset_n_sync,
    input  wire scan_strobe_t scan,
    input  wire ir_code_t     ir,
    output logic              tdo,
    output byte_t             source_data,
    output logic              source_valid,
    input  wire byte_t        sink_data,
    input  wire               sink_valid,
    output logic              sink_ready,
    output logic              reset_request
);

    logic         data_selected;
    logic         data_tdo;
    logic         aux_tdo;
    offset_t      offset;
    header_info_t header_info;

    assign data_selected = (ir == IR_DATA);

    // selected DR bit 0, only while shifting
    assign tdo = scan.shift && (data_selected ? data_tdo : aux_tdo);

    frame_write_path u_write_path (
        .clock_to_sample          (clock_to_sample),
        .clock_sense_reset_n_sync (clock_sense_reset_n_sync),
        .scan                     (scan),
        .data_selected            (data_selected),
        .offset                   (offset),
        .header_info              (header_info),
        .source_data              (source_data),
        .source_valid             (source_valid)
    );

    frame_read_path u_read_path (
        .clock_to_sample          (clock_to_sample),
        .clock_sense_reset_n_sync (clock_sense_reset_n_sync),
        .scan                     (scan),
        .data_selected            (data_selected),
        .offset                   (offset),
        .header_info              (header_info),
        .sink_data                (sink_data),
        .sink_valid               (sink_valid),
        .sink_ready               (sink_ready),
        .data_tdo                 (data_tdo)
    );

    aux_registers u_aux_registers (
        .clock_to_sample          (clock_to_sample),
        .clock_sense_reset_n_sync (clock_sense_reset_n_sync),
        .scan                     (scan),
        .ir                       (ir),
        .offset                   (offset),
        .reset_request            (reset_request),
        .aux_tdo                  (aux_tdo)
    );

endmodule

`default_nettype wire

/* hdl/scan_pkg.sv */
`default_nettype none

package scan_pkg;

    typedef logic [2:0] ir_code_t;

    // virtual IR codes
    localparam ir_code_t IR_DATA     = 3'd0;
    localparam ir_code_t IR_LOOPBACK = 3'd1;
    localparam ir_code_t IR_DEBUG    = 3'd2; // nothing behind it, reads zeros
    localparam ir_code_t IR_INFO     = 3'd3;
    localparam ir_code_t IR_CONTROL  = 3'd4;

    // DR strobes as seen on clock_to_sample
    // only one of capture, shift and update is high in a given cycle
    typedef struct packed {
        logic capture;
        logic shift;
        logic update;
        logic tdi;
    } scan_strobe_t;

    localparam int INFO_WIDTH    = 11;
    localparam int CONTROL_WIDTH = 9; // offset plus reset request

endpackage

`default_nettype wire

/* hdl/stream_pkg.sv */
`default_nettype none

package stream_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  offset_t;     // bypass bits ahead of the header
    typedef logic [9:0]  scan_len_t;
    typedef logic [2:0]  len_code_t;
    typedef logic [18:0] byte_count_t;
    typedef logic [8:0]  pad_count_t;

    // decoded header fields handed from the write side to the read side
    typedef struct packed {
        logic      load;
        scan_len_t scan_len;
        len_code_t read_len;
    } header_info_t;

    localparam int HEADER_BITS = 16;

    localparam byte_t FILL_BYTE = 8'h4a;

    localparam len_code_t LEN_NONE = 3'd0;
    localparam len_code_t LEN_ALL  = 3'd7;

    // identity word fields
    localparam logic [2:0] INFO_PURPOSE  = 3'd2;
    localparam logic [3:0] UP_ENC_SIZE   = 4'd6;
    localparam logic [3:0] DOWN_ENC_SIZE = 4'd5;

    // bytes in a scan, less one
    function automatic byte_count_t scan_byte_count(scan_len_t len);
        return byte_count_t'({len, 8'hff});
    endfunction

    // codes 1 to 6, 128 << n bytes
    function automatic byte_count_t decode_len(len_code_t code);
        return (code == LEN_NONE) ? byte_count_t'(0) : (byte_count_t'(128) << code);
    endfunction

endpackage

`default_nettype wire

/* sources.f */
hdl/scan_pkg.sv
hdl/stream_pkg.sv
hdl/frame_write_path.sv
hdl/frame_read_path.sv
hdl/aux_registers.sv
hdl/jtag_stream_bridge.sv
verification/jtag_stream_bridge_tb.sv

/* verification/jtag_stream_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_stream_bridge_tb
    import scan_pkg::*, stream_pkg::*;
();

    logic         clock_to_sample;
    logic         clock_sense_reset_n_sync;
    scan_strobe_t scan;
    ir_code_t     ir;
    logic         tdo;
    byte_t        source_data;
    logic         source_valid;
    byte_t        sink_data;
    logic         sink_valid;
    logic         sink_ready;
    logic         reset_request;

    byte_t  stim [0:511];
    byte_t  sink_mem [0:15];
    byte_t  source_got [$];
    int     sink_count;
    int     sink_pos;
    logic   sink_taken;
    int     error_count;
    int     test_errors;
    int     check_count;
    int     timeout_cycles;
    logic   timeout_armed;
    integer seed = 90779;

    jtag_stream_bridge UUT (
        .clock_to_sample          (clock_to_sample),
        .clock_sense_reset_n_sync (clock_sense_reset_n_sync),
        .scan                     (scan),
        .ir                       (ir),
        .tdo                      (tdo),
        .source_data              (source_data),
        .source_valid             (source_valid),
        .sink_data                (sink_data),
        .sink_valid               (sink_valid),
        .sink_ready               (sink_ready),
        .reset_request            (reset_request)
    );

    always #5 clock_to_sample = ~clock_to_sample;

    // handshake seen here completes on the following rising edge
    always @(negedge clock_to_sample) begin
        sink_taken = sink_ready && sink_valid;
        if (source_valid === 1'b1) begin
            source_got.push_back(source_data);
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            test_errors++;
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // all inputs change 1 ns after the edge, the sink moves on after a handshake
    task automatic next_cycle(input scan_strobe_t s);
        @(posedge clock_to_sample);
        #1;
        if (sink_taken) begin
            sink_pos++;
        end
        sink_valid = (sink_pos < sink_count);
        sink_data  = (sink_pos < sink_count) ? sink_mem[sink_pos] : 8'h00;
        scan       = s;
    endtask

    task automatic capture_dr();
        scan_strobe_t s;
        s         = '0;
        s.capture = 1'b1;
        next_cycle(s);
    endtask

    task automatic update_dr();
        scan_strobe_t s;
        s        = '0;
        s.update = 1'b1;
        next_cycle(s);
    endtask

    task automatic shift_bits(input int tdi_at, input int tdo_at, input int nbits);
        scan_strobe_t s;
        int           i;
        int           gap;
        for (i = 0; i < nbits; i++) begin
            s       = '0;
            s.shift = 1'b1;
            s.tdi   = stim[tdi_at + i / 8][i % 8];
            next_cycle(s);
            @(negedge clock_to_sample); // tdo settled well before the edge
            check_value(tdo, stim[tdo_at + i / 8][i % 8], $sformatf("tdo bit %0d", i));
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) next_cycle('0);
        end
    endtask

    function automatic logic record_present(input int p);
        return p < 480 && !$isunknown(stim[p]) && stim[p] != 8'hff;
    endfunction

    function automatic int count_scan_bits(output int tests);
        int p;
        int nbytes;
        int total;
        p     = 0;
        total = 0;
        tests = 0;
        while (record_present(p)) begin
            nbytes = (stim[p + 1] + 7) / 8;
            total += stim[p + 1];
            tests++;
            p = p + 3 + 2 * nbytes;
            p = p + 1 + stim[p]; // sink bytes
            p = p + 1 + stim[p]; // source bytes
        end
        return total;
    endfunction

    task automatic run_test(inout int p, input int number);
        int   nbits;
        int   nbytes;
        int   tdi_at;
        int   tdo_at;
        int   src_n;
        int   i;
        logic exp_reset;
        ir        = stim[p][2:0];
        nbits     = stim[p + 1];
        exp_reset = stim[p + 2][0];
        nbytes    = (nbits + 7) / 8;
        tdi_at    = p + 3;
        tdo_at    = tdi_at + nbytes;
        p         = tdo_at + nbytes;
        sink_count = stim[p];
        for (i = 0; i < sink_count; i++) begin
            sink_mem[i] = stim[p + 1 + i];
        end
        sink_pos    = 0;
        p           = p + 1 + sink_count;
        src_n       = stim[p];
        test_errors = 0;
        source_got.delete();
        next_cycle('0); // new instruction settles before capture
        capture_dr();
        shift_bits(tdi_at, tdo_at, nbits);
        update_dr();
        repeat (2) next_cycle('0);
        check_value(reset_request, exp_reset, "reset_request");
        check_value(source_got.size(), src_n, "source byte count");
        for (i = 0; i < src_n && i < source_got.size(); i++) begin
            check_value(source_got[i], stim[p + 1 + i], $sformatf("source byte %0d", i));
        end
        p = p + 1 + src_n;
        $display("test %0d ir %0d, %0d scan bits: %0d errors", number, stim[tdi_at - 3],
                 nbits, test_errors);
    endtask

    initial begin
        int p;
        int number;
        int tests;
        int total_bits;
        clock_to_sample          = 1'b0;
        clock_sense_reset_n_sync = 1'b0;
        scan        = '0;
        ir          = IR_DATA;
        sink_data   = 8'h00;
        sink_valid  = 1'b0;
        sink_count  = 0;
        sink_pos    = 0;
        sink_taken  = 1'b0;
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        $readmemh("verification/scan_stimulus.txt", stim);
        total_bits     = count_scan_bits(tests);
        timeout_cycles = total_bits * 4 + tests * 10 + 100;
        timeout_armed  = 1'b1;

        repeat (5) @(posedge clock_to_sample);
        #1;
        clock_sense_reset_n_sync = 1'b1;

        next_cycle('0);
        @(negedge clock_to_sample);
        check_value(source_valid, 0, "source_valid after reset");
        check_value(sink_ready, 0, "sink_ready after reset");
        check_value(reset_request, 0, "reset_request after reset");
        check_value(tdo, 0, "tdo after reset");
        $display("test 1 idle after reset: %0d errors", test_errors);

        if (tests == 0) begin
            error_count++;
            $display("error: no tests were found in the stimulus file");
        end
        next_cycle('0); // the first instruction change lands just after an edge
        p      = 0;
        number = 1;
        while (record_present(p)) begin
            number++;
            run_test(p, number);
        end

        $display("tests %0d, checks %0d, errors %0d", number, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog, roughly four cycles per scan bit plus setup per test
    initial begin
        wait (timeout_armed === 1'b1);
        repeat (timeout_cycles) @(posedge clock_to_sample);
        $display("timeout: the scan tests did not finish within %0d cycles", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/scan_stimulus.txt */
// ir, scan bits, reset_request after update, tdi bytes, expected tdo bytes (lsb first,
// one byte per 8 scan bits), sink count and bytes, source count and bytes; ff ends the list
// loopback, tdo is tdi one bit late with a leading 0
01 10 00  a5 3c  4a 79  00  00
// info word {2, 6, 5} then zeros
03 10 00  00 00  65 02  00  00
// data, write code 7, read code 0, no sink bytes
00 30 00  00 e0 a1 b2 c3 d4
          00 00 4a 4a 4a 4a
          00  04 a1 b2 c3 d4
// data, read code 7, three sink bytes then fill, writes dropped
00 38 00  00 1c 99 99 99 99 99
          01 00 10 20 30 4a 4a
          03 10 20 30  00
// data, read code 0, sink bytes offered but only fill goes out
00 20 00  00 00 55 66  01 00 4a 4a  02 77 88  00
// control, offset 8
04 09 00  08 00  00 00  00  00
// data behind 8 bypass bits, 8 fill bits after the status word
00 30 00  ff 00 fc 11 22 33
          01 00 4a 5a c3 4a
          02 5a c3  03 11 22 33
// control, offset 8 with reset request
04 09 01  08 01  00 00  00  00
// control cleared
04 09 00  00 00  00 00  00  00
ff
